//--- src/cart_pkg.sv
// Cartridge register map and constants
package cart_pkg;

	// Bus widths
	localparam int data_w      = 16;
	localparam int host_addr_w = 8;
	localparam int ss_index_w  = 4;

	// Identification words, "SR" and hw/sw revision
	localparam logic [data_w-1:0] cart_id  = 16'h5253;
	localparam logic [data_w-1:0] cart_ver = 16'h1206;

	// Sector FIFO sizing
	localparam int fifo_depth = 256;
	localparam int fifo_cnt_w = 9;
	localparam int rcnt_w     = 16;

	// CTRL bit positions, three enables start at irq_en_lo
	localparam int ctrl_irq_en_lo  = 0;
	localparam int ctrl_fifo_reset = 8;
	localparam int ctrl_fifo_dir   = 9;

	// Host register addresses, byte offsets
	typedef enum logic [host_addr_w-1:0] {
		HREG_ID        = 8'h00,
		HREG_VER       = 8'h02,
		HREG_CTRL      = 8'h04,
		HREG_STAT      = 8'h06,
		HREG_FIFO      = 8'h08,
		HREG_FIFO_STAT = 8'h0C,
		HREG_RCNT      = 8'h0E,
		HREG_CMD       = 8'h10,
		HREG_DATA      = 8'h12,
		HREG_RESP1     = 8'h18,
		HREG_RESP2     = 8'h1A,
		HREG_RESP3     = 8'h1C,
		HREG_RESP4     = 8'h1E,
		HREG_CR1       = 8'h20,
		HREG_CR2       = 8'h22,
		HREG_CR3       = 8'h24,
		HREG_CR4       = 8'h26,
		HREG_HIRQ_SET  = 8'h28,
		HREG_HIRQ_MASK = 8'h2A,
		HREG_HIRQ_CLR  = 8'h2C
	} host_reg_e;

	// Console CDC window, word index from address bits 5:2
	typedef enum logic [ss_index_w-1:0] {
		CIDX_FIFO = 4'd0,
		CIDX_HIRQ = 4'd2,
		CIDX_MASK = 4'd3,
		CIDX_CR1  = 4'd6,
		CIDX_CR2  = 4'd7,
		CIDX_CR3  = 4'd8,
		CIDX_CR4  = 4'd9
	} cdc_idx_e;

	// Console system window
	typedef enum logic [ss_index_w-1:0] {
		BIDX_ID   = 4'd0,
		BIDX_STAT = 4'd2,
		BIDX_CMD  = 4'd4,
		BIDX_DATA = 4'd5
	} bcr_idx_e;

endpackage

//--- src/bus_pkg.sv
// Bus transfer and status structs
package bus_pkg;

	// One captured host transfer
	typedef struct packed {
		logic                        write;
		cart_pkg::host_reg_e         addr;
		logic [cart_pkg::data_w-1:0] data;
	} host_acc_t;

	// Console address windows on CS2
	typedef enum logic [1:0] {
		NONE = 2'd0,
		CDC  = 2'd1,
		BCR  = 2'd2
	} ss_win_e;

	// One captured console transfer
	typedef struct packed {
		ss_win_e                         win;
		logic [cart_pkg::ss_index_w-1:0] index;
		logic [cart_pkg::data_w-1:0]     data;
	} ss_acc_t;

	// Sector FIFO fill state
	typedef struct packed {
		logic                            full;
		logic                            empty;
		logic [cart_pkg::fifo_cnt_w-1:0] count;
	} fifo_stat_t;

	// Host interrupt sources, bit order matches STAT[2:0]
	typedef struct packed {
		logic fifo;
		logic cmd;
		logic cdc;
	} irq_flags_t;

endpackage

//--- src/host_port.sv
// Host req/ack port
`timescale 1ns/1ps

module host_port
(
	input  logic                        mclk,
	input  logic                        ST_ALE,
	input  logic                        host_req,
	input  logic                        host_write,
	input  cart_pkg::host_reg_e         host_addr,
	input  logic [cart_pkg::data_w-1:0] host_wdata,
	output logic                        host_ack,
	output bus_pkg::host_acc_t          acc,
	output logic                        rd_start,
	output logic                        wr_start
);

	// Capture, pulse, then hold ack until req drops
	typedef enum logic [1:0] {IDLE, ISSUE, ACK} state_e;

	state_e state;

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			state    <= IDLE;
			host_ack <= 1'b0;
			rd_start <= 1'b0;
			wr_start <= 1'b0;
		end
		else
		begin
			// Start strobes last one cycle
			rd_start <= 1'b0;
			wr_start <= 1'b0;
			case (state)
			IDLE:
				if (host_req)
					state <= ISSUE;
			ISSUE:
			begin
				rd_start <= !acc.write;
				wr_start <= acc.write;
				state    <= ACK;
			end
			ACK:
				// Ack rises here, falls once req is seen low
				if (host_ack && !host_req)
				begin
					host_ack <= 1'b0;
					state    <= IDLE;
				end
				else
					host_ack <= 1'b1;
			default:
				state <= IDLE;
			endcase
		end
	end

	// Access stays frozen until the next accepted request
	always_ff @(posedge mclk)
	begin
		if (state == IDLE && host_req)
			acc <= {host_write, host_addr, host_wdata};
	end

endmodule

//--- src/abus_port.sv
// Console bus strobe decoder
`timescale 1ns/1ps

module abus_port
(
	input  logic                        mclk,
	input  logic                        ST_ALE,
	input  logic                        ss_cs2_n,
	input  logic                        ss_rd_n,
	input  logic                        ss_wr_n,
	input  logic [15:0]                 ss_addr,
	input  logic [cart_pkg::data_w-1:0] ss_wdata,
	output bus_pkg::ss_acc_t            acc,
	output logic                        rd_start,
	output logic                        wr_start
);

	import bus_pkg::*;

	// [0],[1] two-flop synchronizer, [2] previous value for edge
	logic [2:0] cs_sync;
	logic       cs_fall;
	ss_win_e    win;

	// Window select from address bits 14:12
	always_comb
	begin
		case (ss_addr[14:12])
		3'b000:  win = CDC;
		3'b111:  win = BCR;
		default: win = NONE;
		endcase
	end

	assign cs_fall = cs_sync[2] && !cs_sync[1];

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			cs_sync  <= 3'b111;
			rd_start <= 1'b0;
			wr_start <= 1'b0;
		end
		else
		begin
			cs_sync  <= {cs_sync[1:0], ss_cs2_n};
			// Unmapped windows never strobe
			rd_start <= cs_fall && win != NONE && !ss_rd_n;
			wr_start <= cs_fall && win != NONE && !ss_wr_n;
		end
	end

	// Strobes have settled by the synchronized edge
	always_ff @(posedge mclk)
	begin
		if (cs_fall)
		begin
			acc.win   <= win;
			acc.index <= ss_addr[5:2];
			acc.data  <= ss_wdata;
		end
	end

endmodule

//--- src/cdc_regs.sv
// CD controller and mailbox registers
`timescale 1ns/1ps

module cdc_regs
(
	input  logic                             mclk,
	input  logic                             ST_ALE,
	input  bus_pkg::host_acc_t               host_acc,
	input  logic                             host_wr_start,
	input  bus_pkg::ss_acc_t                 ss_acc,
	input  logic                             ss_rd_start,
	input  logic                             ss_wr_start,
	input  logic                             fifo_empty_edge,
	output logic [cart_pkg::data_w-1:0]      ctrl,
	output bus_pkg::irq_flags_t              flags,
	output logic                             in_cmd,
	output logic [cart_pkg::data_w-1:0]      hirq,
	output logic [cart_pkg::data_w-1:0]      hirq_mask,
	output logic [cart_pkg::data_w-1:0]      cmd_word,
	output logic [cart_pkg::data_w-1:0]      data_word,
	output logic [3:0][cart_pkg::data_w-1:0] cr,
	output logic [3:0][cart_pkg::data_w-1:0] resp
);

	import cart_pkg::*;
	import bus_pkg::*;

	logic [data_w-1:0] hirq_next;
	irq_flags_t        flag_set;
	irq_flags_t        flag_clr;

	// Host write hit
	function automatic logic h_wr(host_reg_e a);
		return host_wr_start && host_acc.addr == a;
	endfunction

	// Console write hit in the CDC window
	function automatic logic c_wr(cdc_idx_e i);
		return ss_wr_start && ss_acc.win == CDC && ss_acc.index == i;
	endfunction

	// Console write hit in the system window
	function automatic logic b_wr(bcr_idx_e i);
		return ss_wr_start && ss_acc.win == BCR && ss_acc.index == i;
	endfunction

	////////////////////////////////////////////////////////////
	// HIRQ and interrupt flags
	////////////////////////////////////////////////////////////

	always_comb
	begin
		hirq_next = hirq;
		// Host side first
		if (h_wr(HREG_HIRQ_SET))
			hirq_next = hirq_next | host_acc.data;
		else if (h_wr(HREG_HIRQ_CLR))
			hirq_next = hirq_next & ~host_acc.data;
		// Console AND-clear lands on top
		if (c_wr(CIDX_HIRQ))
			hirq_next = hirq_next & ss_acc.data;

		flag_set.fifo = fifo_empty_edge;
		flag_set.cmd  = b_wr(BIDX_CMD);
		flag_set.cdc  = c_wr(CIDX_CR4);
		// Write-one-to-clear through STAT
		flag_clr = h_wr(HREG_STAT) ? irq_flags_t'(host_acc.data[2:0]) : '0;
	end

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			ctrl     <= '0;
			hirq     <= '0;
			flags    <= '0;
			in_cmd   <= 1'b0;
			cmd_word <= '0;
		end
		else
		begin
			hirq  <= hirq_next;
			// A new event wins over a clear
			flags <= (flags & ~flag_clr) | flag_set;
			if (h_wr(HREG_CTRL))
				ctrl <= host_acc.data;
			// CR4 opens a command, console reading CR4 closes it
			if (c_wr(CIDX_CR4))
				in_cmd <= 1'b1;
			else if (ss_rd_start && ss_acc.win == CDC && ss_acc.index == CIDX_CR4)
				in_cmd <= 1'b0;
			// Host acknowledges the command by zeroing it
			if (h_wr(HREG_CMD))
				cmd_word <= '0;
			else if (b_wr(BIDX_CMD))
				cmd_word <= ss_acc.data;
		end
	end

	////////////////////////////////////////////////////////////
	// Data registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk)
	begin
		// Shared DATA word, console has priority
		if (b_wr(BIDX_DATA))
			data_word <= ss_acc.data;
		else if (h_wr(HREG_DATA))
			data_word <= host_acc.data;
		if (c_wr(CIDX_MASK))
			hirq_mask <= ss_acc.data;
		// Console commands
		if (c_wr(CIDX_CR1))
			cr[0] <= ss_acc.data;
		if (c_wr(CIDX_CR2))
			cr[1] <= ss_acc.data;
		if (c_wr(CIDX_CR3))
			cr[2] <= ss_acc.data;
		if (c_wr(CIDX_CR4))
			cr[3] <= ss_acc.data;
		// Host responses
		if (h_wr(HREG_RESP1))
			resp[0] <= host_acc.data;
		if (h_wr(HREG_RESP2))
			resp[1] <= host_acc.data;
		if (h_wr(HREG_RESP3))
			resp[2] <= host_acc.data;
		if (h_wr(HREG_RESP4))
			resp[3] <= host_acc.data;
	end

endmodule

//--- src/sector_fifo.sv
// Sector data FIFO
`timescale 1ns/1ps

module sector_fifo
(
	input  logic                        mclk,
	input  logic                        ST_ALE,
	input  logic                        dir,
	input  logic                        soft_reset,
	input  bus_pkg::host_acc_t          host_acc,
	input  logic                        host_rd_start,
	input  logic                        host_wr_start,
	input  bus_pkg::ss_acc_t            ss_acc,
	input  logic                        ss_rd_start,
	input  logic                        ss_wr_start,
	output logic [cart_pkg::data_w-1:0] host_q,
	output logic [cart_pkg::data_w-1:0] ss_q,
	output bus_pkg::fifo_stat_t         stat,
	output logic [cart_pkg::rcnt_w-1:0] rcnt,
	output logic                        empty_edge
);

	import cart_pkg::*;
	import bus_pkg::*;

	logic [data_w-1:0]       mem [fifo_depth];
	logic [fifo_cnt_w-2:0]   wr_ptr;
	logic [fifo_cnt_w-2:0]   rd_ptr;
	logic [fifo_cnt_w-1:0]   count;
	logic                    empty_d;
	logic                    host_hit;
	logic                    ss_hit;
	logic                    push;
	logic                    pop;
	logic [data_w-1:0]       push_data;
	logic [data_w-1:0]       q;

	assign host_hit = host_acc.addr == HREG_FIFO;
	assign ss_hit   = ss_acc.win == CDC && ss_acc.index == CIDX_FIFO;

	// dir 0 host to console, dir 1 console to host
	assign push = (dir ? ss_wr_start && ss_hit : host_wr_start && host_hit) && !stat.full;
	assign pop  = (dir ? host_rd_start && host_hit : ss_rd_start && ss_hit) && !stat.empty;

	// Console is big endian so swap on the way in
	assign push_data = dir ? {ss_acc.data[7:0], ss_acc.data[15:8]} : host_acc.data;

	assign q      = mem[rd_ptr];
	assign host_q = q;
	assign ss_q   = {q[7:0], q[15:8]};

	assign stat       = '{full: count == fifo_cnt_w'(fifo_depth), empty: count == '0,
			count: count};
	assign empty_edge = stat.empty && !empty_d;

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			empty_d <= 1'b1;
			rcnt    <= '0;
		end
		else
		begin
			empty_d <= stat.empty;
			if (soft_reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				wr_ptr <= wr_ptr + (fifo_cnt_w-1)'(push);
				rd_ptr <= rd_ptr + (fifo_cnt_w-1)'(pop);
				count  <= count + fifo_cnt_w'(push) - fifo_cnt_w'(pop);
			end
			// Words taken by the console
			if (host_wr_start && host_acc.addr == HREG_RCNT)
				rcnt <= '0;
			else if (pop && !dir)
				rcnt <= rcnt + 1'b1;
		end
	end

	always_ff @(posedge mclk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- src/readback.sv
// Read multiplexers and interrupt outputs
`timescale 1ns/1ps

module readback
(
	input  logic                             mclk,
	input  bus_pkg::host_acc_t               host_acc,
	input  logic                             host_rd_start,
	input  bus_pkg::ss_acc_t                 ss_acc,
	input  logic                             ss_rd_start,
	input  logic [cart_pkg::data_w-1:0]      ctrl,
	input  bus_pkg::irq_flags_t              flags,
	input  logic                             in_cmd,
	input  logic [cart_pkg::data_w-1:0]      hirq,
	input  logic [cart_pkg::data_w-1:0]      hirq_mask,
	input  logic [cart_pkg::data_w-1:0]      cmd_word,
	input  logic [cart_pkg::data_w-1:0]      data_word,
	input  logic [3:0][cart_pkg::data_w-1:0] cr,
	input  logic [3:0][cart_pkg::data_w-1:0] resp,
	input  bus_pkg::fifo_stat_t              stat,
	input  logic [cart_pkg::data_w-1:0]      host_q,
	input  logic [cart_pkg::data_w-1:0]      ss_q,
	input  logic [cart_pkg::rcnt_w-1:0]      rcnt,
	output logic [cart_pkg::data_w-1:0]      host_rdata,
	output logic [cart_pkg::data_w-1:0]      ss_rdata,
	output logic                             host_irq,
	output logic                             ss_irq
);

	import cart_pkg::*;
	import bus_pkg::*;

	logic [data_w-1:0] stat_word;
	logic [data_w-1:0] fifo_word;
	logic [data_w-1:0] host_mux;
	logic [data_w-1:0] ss_mux;

	// irq at bit 14, in_cmd at bit 12, flags in the low bits
	assign stat_word = {1'b0, host_irq, 1'b0, in_cmd, 9'h000, flags};
	assign fifo_word = {5'h00, stat.empty, stat.full, stat.count};

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (host_acc.addr)
		HREG_ID:        host_mux = cart_id;
		HREG_VER:       host_mux = cart_ver;
		HREG_CTRL:      host_mux = ctrl;
		HREG_STAT:      host_mux = stat_word;
		HREG_FIFO:      host_mux = host_q;
		HREG_FIFO_STAT: host_mux = fifo_word;
		HREG_RCNT:      host_mux = rcnt;
		HREG_CMD:       host_mux = cmd_word;
		HREG_DATA:      host_mux = data_word;
		HREG_RESP1:     host_mux = resp[0];
		HREG_RESP2:     host_mux = resp[1];
		HREG_RESP3:     host_mux = resp[2];
		HREG_RESP4:     host_mux = resp[3];
		HREG_CR1:       host_mux = cr[0];
		HREG_CR2:       host_mux = cr[1];
		HREG_CR3:       host_mux = cr[2];
		HREG_CR4:       host_mux = cr[3];
		HREG_HIRQ_SET:  host_mux = hirq;
		HREG_HIRQ_MASK: host_mux = hirq_mask;
		default:        host_mux = 16'hFFFF;
		endcase

		ss_mux = '0;
		// Console sees responses where it wrote commands
		if (ss_acc.win == CDC)
		begin
			case (ss_acc.index)
			CIDX_FIFO: ss_mux = ss_q;
			CIDX_HIRQ: ss_mux = hirq;
			CIDX_MASK: ss_mux = hirq_mask;
			CIDX_CR1:  ss_mux = resp[0];
			CIDX_CR2:  ss_mux = resp[1];
			CIDX_CR3:  ss_mux = resp[2];
			CIDX_CR4:  ss_mux = resp[3];
			default:   ss_mux = '0;
			endcase
		end
		else if (ss_acc.win == BCR)
		begin
			case (ss_acc.index)
			BIDX_ID:   ss_mux = cart_id;
			BIDX_STAT: ss_mux = fifo_word;
			BIDX_CMD:  ss_mux = cmd_word;
			BIDX_DATA: ss_mux = data_word;
			default:   ss_mux = '0;
			endcase
		end
	end

	// Sample before a FIFO pop moves the read pointer
	always_ff @(posedge mclk)
	begin
		if (host_rd_start)
			host_rdata <= host_mux;
		if (ss_rd_start)
			ss_rdata <= ss_mux;
	end

	assign host_irq = |(flags & ctrl[ctrl_irq_en_lo +: $bits(irq_flags_t)]);
	assign ss_irq   = |(hirq & hirq_mask);

endmodule

//--- src/cart_top.sv
// Cartridge bridge top level
`timescale 1ns/1ps

module cart_top
(
	input  logic                        mclk,
	input  logic                        ST_ALE,
	// Host port
	input  logic                        host_req,
	input  logic                        host_write,
	input  cart_pkg::host_reg_e         host_addr,
	input  logic [cart_pkg::data_w-1:0] host_wdata,
	output logic                        host_ack,
	output logic [cart_pkg::data_w-1:0] host_rdata,
	output logic                        host_irq,
	// Console bus
	input  logic                        ss_cs2_n,
	input  logic                        ss_rd_n,
	input  logic                        ss_wr_n,
	input  logic [15:0]                 ss_addr,
	input  logic [cart_pkg::data_w-1:0] ss_wdata,
	output logic [cart_pkg::data_w-1:0] ss_rdata,
	output logic                        ss_irq
);

	import cart_pkg::*;
	import bus_pkg::*;

	host_acc_t                h_acc;
	logic                     h_rd;
	logic                     h_wr;
	ss_acc_t                  s_acc;
	logic                     s_rd;
	logic                     s_wr;
	logic [data_w-1:0]        ctrl;
	irq_flags_t               flags;
	logic                     in_cmd;
	logic [data_w-1:0]        hirq;
	logic [data_w-1:0]        hirq_mask;
	logic [data_w-1:0]        cmd_word;
	logic [data_w-1:0]        data_word;
	logic [3:0][data_w-1:0]   cr;
	logic [3:0][data_w-1:0]   resp;
	fifo_stat_t               stat;
	logic [data_w-1:0]        host_q;
	logic [data_w-1:0]        ss_q;
	logic [rcnt_w-1:0]        rcnt;
	logic                     empty_edge;

	// Bus front ends
	host_port u_host (.mclk, .ST_ALE, .host_req, .host_write, .host_addr, .host_wdata,
			.host_ack, .acc(h_acc), .rd_start(h_rd), .wr_start(h_wr));

	abus_port u_abus (.mclk, .ST_ALE, .ss_cs2_n, .ss_rd_n, .ss_wr_n, .ss_addr, .ss_wdata,
			.acc(s_acc), .rd_start(s_rd), .wr_start(s_wr));

	// Register file and sector buffer
	cdc_regs u_regs (.mclk, .ST_ALE, .host_acc(h_acc), .host_wr_start(h_wr),
			.ss_acc(s_acc), .ss_rd_start(s_rd), .ss_wr_start(s_wr),
			.fifo_empty_edge(empty_edge), .ctrl, .flags, .in_cmd, .hirq, .hirq_mask,
			.cmd_word, .data_word, .cr, .resp);

	sector_fifo u_fifo (.mclk, .ST_ALE, .dir(ctrl[ctrl_fifo_dir]),
			.soft_reset(ctrl[ctrl_fifo_reset]), .host_acc(h_acc), .host_rd_start(h_rd),
			.host_wr_start(h_wr), .ss_acc(s_acc), .ss_rd_start(s_rd), .ss_wr_start(s_wr),
			.host_q, .ss_q, .stat, .rcnt, .empty_edge);

	// Read data and interrupts
	readback u_rb (.mclk, .host_acc(h_acc), .host_rd_start(h_rd), .ss_acc(s_acc),
			.ss_rd_start(s_rd), .ctrl, .flags, .in_cmd, .hirq, .hirq_mask, .cmd_word,
			.data_word, .cr, .resp, .stat, .host_q, .ss_q, .rcnt, .host_rdata, .ss_rdata,
			.host_irq, .ss_irq);

endmodule

//--- testbench/tb_tasks.svh
// Testbench bus drivers and checks
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

// Console words travel big endian
function automatic logic [data_w-1:0] swap_bytes(input logic [data_w-1:0] w);
	return {w[7:0], w[15:8]};
endfunction

// Word-spaced host register, base plus step
function automatic host_reg_e host_reg_at(input host_reg_e base, input int step);
	return host_reg_e'(8'(int'(base) + 2 * step));
endfunction

// FIFO_STAT layout, empty at bit 10 and full at bit 9
function automatic logic [data_w-1:0] fifo_stat_word(input logic empty, input logic full,
		input int count);
	return {5'h00, empty, full, fifo_cnt_w'(count)};
endfunction

function automatic irq_flags_t make_flags(input logic fifo, input logic cmd, input logic cdc);
	irq_flags_t f;
	f.fifo = fifo;
	f.cmd  = cmd;
	f.cdc  = cdc;
	return f;
endfunction

////////////////////////////////////////////////////////////
// Host port
////////////////////////////////////////////////////////////

// Poll ack on falling edges until it reaches the level
task automatic wait_ack(input logic level, input string what);
	int cycles;
	cycles = 0;
	do
	begin
		@(negedge mclk);
		cycles++;
	end
	while (host_ack !== level && cycles < ack_timeout);
	if (host_ack !== level)
		timeout_abort(what);
endtask

task automatic host_write(input host_reg_e addr, input logic [data_w-1:0] data);
	@(posedge mclk);
	host_req   <= 1'b1;
	host_we    <= 1'b1;
	host_addr  <= addr;
	host_wdata <= data;
	wait_ack(1'b1, "host ack did not rise after a write request");
	@(posedge mclk);
	host_req <= 1'b0;
	wait_ack(1'b0, "host ack did not fall after a write");
endtask

task automatic host_read(input host_reg_e addr, output logic [data_w-1:0] data);
	@(posedge mclk);
	host_req   <= 1'b1;
	host_we    <= 1'b0;
	host_addr  <= addr;
	host_wdata <= '0;
	wait_ack(1'b1, "host ack did not rise after a read request");
	// Read data holds while ack is high
	data = host_rdata;
	@(posedge mclk);
	host_req <= 1'b0;
	wait_ack(1'b0, "host ack did not fall after a read");
endtask

////////////////////////////////////////////////////////////
// Console bus
////////////////////////////////////////////////////////////

// One CS2 cycle, select held until read data has settled
task automatic ss_access(input logic write, input ss_win_e win, input logic [3:0] index,
		input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata);
	logic [15:0] addr;
	addr = 16'h0000;
	case (win)
	CDC:     addr[14:12] = 3'b000;
	BCR:     addr[14:12] = 3'b111;
	default: addr[14:12] = 3'b010;
	endcase
	addr[5:2] = index;
	@(posedge mclk);
	ss_cs2_n <= 1'b0;
	ss_rd_n  <= write;
	ss_wr_n  <= !write;
	ss_addr  <= addr;
	ss_wdata <= wdata;
	// Data valid five cycles after the select falls
	repeat (5) @(posedge mclk);
	@(negedge mclk);
	rdata = ss_rdata;
	@(posedge mclk);
	ss_cs2_n <= 1'b1;
	ss_rd_n  <= 1'b1;
	ss_wr_n  <= 1'b1;
	// Let the synchronizer see the select high again
	repeat (3) @(posedge mclk);
endtask

////////////////////////////////////////////////////////////
// Compares
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s: got 0x%04h, expected 0x%04h", name, got, exp);
		errors++;
	end
endtask

task automatic check_flags(input string name, input irq_flags_t got, input irq_flags_t exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s: got 0x%01h, expected 0x%01h", name, got, exp);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s: got 0x%01h, expected 0x%01h", name, got, exp);
		errors++;
	end
endtask

`endif

//--- testbench/tb_cart.sv
// Cartridge bridge testbench
`timescale 1ns/1ps

module tb_cart;

	import cart_pkg::*;
	import bus_pkg::*;

	localparam int ack_timeout = 64;
	localparam int burst_len   = 8;

	logic              mclk;
	logic              ST_ALE;
	logic              host_req;
	logic              host_we;
	host_reg_e         host_addr;
	logic [data_w-1:0] host_wdata;
	logic              host_ack;
	logic [data_w-1:0] host_rdata;
	logic              host_irq;
	logic              ss_cs2_n;
	logic              ss_rd_n;
	logic              ss_wr_n;
	logic [15:0]       ss_addr;
	logic [data_w-1:0] ss_wdata;
	logic [data_w-1:0] ss_rdata;
	logic              ss_irq;

	// Run bookkeeping
	int    errors;
	int    tests_run;
	int    tests_failed;
	int    test_errors;
	string test_name;

	cart_top uut (.mclk(mclk), .ST_ALE(ST_ALE), .host_req(host_req), .host_write(host_we),
			.host_addr(host_addr), .host_wdata(host_wdata), .host_ack(host_ack),
			.host_rdata(host_rdata), .host_irq(host_irq), .ss_cs2_n(ss_cs2_n),
			.ss_rd_n(ss_rd_n), .ss_wr_n(ss_wr_n), .ss_addr(ss_addr), .ss_wdata(ss_wdata),
			.ss_rdata(ss_rdata), .ss_irq(ss_irq));

	// 8 ns period
	always #4 mclk = ~mclk;

	`include "tb_tasks.svh"

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = errors;
		tests_run++;
	endtask

	task automatic report_test();
		if (errors == test_errors)
			$display("test %-24s ok", test_name);
		else
		begin
			$display("test %-24s failed, %0d mismatches", test_name, errors - test_errors);
			tests_failed++;
		end
	endtask

	task automatic finish_run();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		$display("TIMEOUT in %s: %s within %0d cycles", test_name, what, ack_timeout);
		errors++;
		finish_run();
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic ident_regs();
		logic [data_w-1:0] rd;
		begin_test("ident");
		host_read(HREG_ID, rd);
		check_word("ID", rd, cart_id);
		host_read(HREG_VER, rd);
		check_word("VER", rd, cart_ver);
		// Hole in the map
		host_read(host_reg_e'(8'h40), rd);
		check_word("unmapped 0x40", rd, 16'hFFFF);
		report_test();
	endtask

	task automatic mailbox_flow();
		logic [data_w-1:0] rd;
		logic [data_w-1:0] cmd;
		logic [data_w-1:0] data;
		begin_test("mailbox");
		cmd  = 16'($urandom);
		data = 16'($urandom);
		ss_access(1'b1, BCR, BIDX_CMD, cmd, rd);
		ss_access(1'b1, BCR, BIDX_DATA, data, rd);
		host_read(HREG_CMD, rd);
		check_word("CMD", rd, cmd);
		host_read(HREG_DATA, rd);
		check_word("DATA", rd, data);
		host_read(HREG_STAT, rd);
		check_flags("STAT flags", irq_flags_t'(rd[2:0]), make_flags(1'b0, 1'b1, 1'b0));
		// Enable only the cmd source
		host_write(HREG_CTRL, 16'(1) << (ctrl_irq_en_lo + 1));
		@(negedge mclk);
		check_bit("host_irq", host_irq, 1'b1);
		host_write(HREG_STAT, 16'h0002);
		@(negedge mclk);
		check_bit("host_irq", host_irq, 1'b0);
		host_write(HREG_CMD, 16'($urandom));
		host_read(HREG_CMD, rd);
		check_word("CMD after ack", rd, 16'h0000);
		report_test();
	endtask

	task automatic cr_response();
		logic [data_w-1:0] rd;
		logic [data_w-1:0] words [4];
		begin_test("cr and response");
		for (int i = 0; i < 4; i++)
		begin
			words[i] = 16'($urandom);
			ss_access(1'b1, CDC, 4'(int'(CIDX_CR1) + i), words[i], rd);
		end
		for (int i = 0; i < 4; i++)
		begin
			host_read(host_reg_at(HREG_CR1, i), rd);
			check_word("CR", rd, words[i]);
		end
		host_read(HREG_STAT, rd);
		check_flags("STAT flags", irq_flags_t'(rd[2:0]), make_flags(1'b0, 1'b0, 1'b1));
		check_bit("in_cmd", rd[12], 1'b1);
		// Responses show up at the CR indices
		for (int i = 0; i < 4; i++)
		begin
			words[i] = 16'($urandom);
			host_write(host_reg_at(HREG_RESP1, i), words[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			ss_access(1'b0, CDC, 4'(int'(CIDX_CR1) + i), 16'h0000, rd);
			check_word("console RESP", rd, words[i]);
		end
		host_write(HREG_STAT, 16'h0001);
		report_test();
	endtask

	// HIRQ readback and the masked console interrupt
	task automatic hirq_check(input logic [data_w-1:0] exp_hirq, input logic [data_w-1:0] mask);
		logic [data_w-1:0] rd;
		host_read(HREG_HIRQ_SET, rd);
		check_word("HIRQ", rd, exp_hirq);
		@(negedge mclk);
		check_bit("ss_irq", ss_irq, |(exp_hirq & mask));
	endtask

	task automatic hirq_mask_irq();
		logic [data_w-1:0] rd;
		logic [data_w-1:0] h;
		logic [data_w-1:0] m;
		logic [data_w-1:0] v;
		begin_test("hirq");
		h = '0;
		m = '0;
		ss_access(1'b1, CDC, CIDX_MASK, m, rd);
		hirq_check(h, m);
		v = 16'($urandom);
		host_write(HREG_HIRQ_SET, v);
		h = h | v;
		hirq_check(h, m);
		v = 16'($urandom);
		host_write(HREG_HIRQ_CLR, v);
		h = h & ~v;
		hirq_check(h, m);
		// Mask covers every pending bit
		m = 16'($urandom) | h;
		ss_access(1'b1, CDC, CIDX_MASK, m, rd);
		host_read(HREG_HIRQ_MASK, rd);
		check_word("HIRQ_MASK", rd, m);
		hirq_check(h, m);
		v = 16'($urandom);
		ss_access(1'b1, CDC, CIDX_HIRQ, v, rd);
		h = h & v;
		hirq_check(h, m);
		ss_access(1'b1, CDC, CIDX_HIRQ, ~m, rd);
		h = h & ~m;
		hirq_check(h, m);
		report_test();
	endtask

	task automatic fifo_host_to_console();
		logic [data_w-1:0] rd;
		logic [data_w-1:0] words [burst_len];
		begin_test("fifo host to console");
		host_write(HREG_CTRL, 16'h0000);
		host_write(HREG_RCNT, 16'h0000);
		for (int i = 0; i < burst_len; i++)
		begin
			words[i] = 16'($urandom);
			host_write(HREG_FIFO, words[i]);
		end
		host_read(HREG_FIFO_STAT, rd);
		check_word("FIFO_STAT", rd, fifo_stat_word(1'b0, 1'b0, burst_len));
		for (int i = 0; i < burst_len; i++)
		begin
			ss_access(1'b0, CDC, CIDX_FIFO, 16'h0000, rd);
			check_word("console FIFO", rd, swap_bytes(words[i]));
		end
		host_read(HREG_RCNT, rd);
		check_word("RCNT", rd, 16'(burst_len));
		host_read(HREG_STAT, rd);
		check_flags("STAT flags", irq_flags_t'(rd[2:0]), make_flags(1'b1, 1'b0, 1'b0));
		host_read(HREG_FIFO_STAT, rd);
		check_word("FIFO_STAT", rd, fifo_stat_word(1'b1, 1'b0, 0));
		host_write(HREG_STAT, 16'h0004);
		report_test();
	endtask

	task automatic fifo_console_to_host();
		logic [data_w-1:0] rd;
		logic [data_w-1:0] dir_bit;
		logic [data_w-1:0] words [burst_len];
		begin_test("fifo console to host");
		dir_bit = 16'(1) << ctrl_fifo_dir;
		host_write(HREG_CTRL, dir_bit);
		for (int i = 0; i < burst_len; i++)
		begin
			words[i] = 16'($urandom);
			ss_access(1'b1, CDC, CIDX_FIFO, words[i], rd);
		end
		host_read(HREG_FIFO_STAT, rd);
		check_word("FIFO_STAT", rd, fifo_stat_word(1'b0, 1'b0, burst_len));
		for (int i = 0; i < burst_len; i++)
		begin
			host_read(HREG_FIFO, rd);
			check_word("host FIFO", rd, swap_bytes(words[i]));
		end
		// Leave two words behind for the soft reset
		ss_access(1'b1, CDC, CIDX_FIFO, 16'($urandom), rd);
		ss_access(1'b1, CDC, CIDX_FIFO, 16'($urandom), rd);
		host_read(HREG_FIFO_STAT, rd);
		check_word("FIFO_STAT", rd, fifo_stat_word(1'b0, 1'b0, 2));
		host_write(HREG_CTRL, dir_bit | (16'(1) << ctrl_fifo_reset));
		host_write(HREG_CTRL, dir_bit);
		host_read(HREG_FIFO_STAT, rd);
		check_word("FIFO_STAT", rd, fifo_stat_word(1'b1, 1'b0, 0));
		report_test();
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(96));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		test_name    = "reset";
		mclk       = 1'b0;
		ST_ALE     = 1'b1;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = HREG_ID;
		host_wdata = '0;
		ss_cs2_n   = 1'b1;
		ss_rd_n    = 1'b1;
		ss_wr_n    = 1'b1;
		ss_addr    = '0;
		ss_wdata   = '0;
		repeat (16) @(posedge mclk);
		ST_ALE <= 1'b0;
		repeat (4) @(posedge mclk);
		ident_regs();
		mailbox_flow();
		cr_response();
		hirq_mask_irq();
		fifo_host_to_console();
		fifo_console_to_host();
		finish_run();
	end

endmodule

//--- verilog.f
+incdir+testbench
src/cart_pkg.sv
src/bus_pkg.sv
src/host_port.sv
src/abus_port.sv
src/cdc_regs.sv
src/sector_fifo.sv
src/readback.sv
src/cart_top.sv
testbench/tb_cart.sv

//--- Bender.yml
package:
  name: cart_bridge

sources:
  - src/cart_pkg.sv
  - src/bus_pkg.sv
  - src/host_port.sv
  - src/abus_port.sv
  - src/cdc_regs.sv
  - src/sector_fifo.sv
  - src/readback.sv
  - src/cart_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cart.sv
